/* design/simd_pkg.sv */
// Packed-SIMD unit shared definitions
// Lane width, operation and mode encodings, CTRL layout, lane flags
// and the Wishbone register map

package simd_pkg;

  // Width of one byte lane
  localparam int LANE_W = 8;

  typedef logic [LANE_W-1:0] byte_t;

  //////////////////////////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_CMPEQ = 3'd2,
    OP_CMPLT = 3'd3,
    OP_CMPLE = 3'd4,
    OP_MIN   = 3'd5,
    OP_MAX   = 3'd6
  } simd_op_e;

  // Result mode for add and sub only
  typedef enum logic [1:0] {
    MODE_WRAP  = 2'd0,
    MODE_SAT   = 2'd1,
    MODE_HALVE = 2'd2
  } sat_mode_e;

  typedef enum logic {
    EW_8  = 1'b0,
    EW_16 = 1'b1
  } elem_width_e;

  // CTRL register bits [6:0] with op in the top three
  typedef struct packed {
    simd_op_e    op;
    sat_mode_e   mode;
    elem_width_e width;
    logic        is_signed;
  } simd_ctrl_t;

  // Per-lane adder outputs
  typedef struct packed {
    byte_t sum;
    logic  carry;
    logic  a_msb;
    logic  b_msb;   // after inversion for subtract
    logic  zero;
  } lane_out_t;

  //////////////////////////////////////////////////////////////////////
  // Register map in word addresses
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    REG_OPA    = 3'd0,
    REG_OPB    = 3'd1,
    REG_CTRL   = 3'd2,
    REG_RESULT = 3'd3,
    REG_STATUS = 3'd4
  } wb_reg_e;

endpackage

/* design/simd_wb_regs.sv */
`timescale 1ns/1ps
// SIMD register block
// Wishbone classic slave holding operands and control, which latches
// the result and overflow status one cycle after each CTRL write

module simd_wb_regs import simd_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  wb_reg_e                     wb_adr_i,
  input  logic [NUM_LANES*LANE_W-1:0] wb_dat_i,
  input  logic [NUM_LANES*LANE_W-1:0] result_i,
  input  logic                        ovf_i,
  output logic [NUM_LANES*LANE_W-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  output logic [NUM_LANES*LANE_W-1:0] opa_o,
  output logic [NUM_LANES*LANE_W-1:0] opb_o,
  output simd_ctrl_t                  ctrl_o
);

  localparam int DW = NUM_LANES * LANE_W;
  localparam int CW = $bits(simd_ctrl_t);

  logic          ack_q;
  logic          start_q;
  logic          bus_req;
  logic [DW-1:0] rd_data;
  logic [DW-1:0] dat_q;
  logic [DW-1:0] opa_q;
  logic [DW-1:0] opb_q;
  logic [DW-1:0] result_q;
  simd_ctrl_t    ctrl_q;
  logic          ovf_q;

  // New request only while no ack is pending
  assign bus_req = wb_cyc_i & wb_stb_i & ~ack_q;

  // Read mux with unmapped words reading as zero
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_OPA:    rd_data = opa_q;
      REG_OPB:    rd_data = opb_q;
      REG_CTRL:   rd_data[CW-1:0] = ctrl_q;
      REG_RESULT: rd_data = result_q;
      REG_STATUS: rd_data[0] = ovf_q;
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      dat_q    <= '0;
      opa_q    <= '0;
      opb_q    <= '0;
      ctrl_q   <= '0;
      result_q <= '0;
      ovf_q    <= 1'b0;
    end else begin
      ack_q   <= bus_req;
      start_q <= bus_req & wb_we_i & (wb_adr_i == REG_CTRL);
      dat_q   <= (bus_req & ~wb_we_i) ? rd_data : '0;
      // Writes land on the edge that raises ack
      if (bus_req && wb_we_i) begin
        case (wb_adr_i)
          REG_OPA:  opa_q  <= wb_dat_i;
          REG_OPB:  opb_q  <= wb_dat_i;
          REG_CTRL: ctrl_q <= simd_ctrl_t'(wb_dat_i[CW-1:0]);
          default:  ;
        endcase
      end
      // Merge output has settled on the new CTRL by now
      if (start_q) begin
        result_q <= result_i;
        ovf_q    <= ovf_i;
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;
  assign opa_o    = opa_q;
  assign opb_o    = opb_q;
  assign ctrl_o   = ctrl_q;

  //////////////////////////////////////////////////////////////////////
  // Bus protocol checks
  //////////////////////////////////////////////////////////////////////

  a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else $error("ack raised without cyc and stb in the previous cycle");

  a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("ack held high for two cycles");

endmodule

/* design/simd_byte_lane.sv */
`timescale 1ns/1ps
// SIMD byte lane
// One 8-bit adder/subtractor slice with element-aware carry in

module simd_byte_lane import simd_pkg::*; #(
  parameter int LANE_IDX = 0
) (
  input  byte_t      a_i,
  input  byte_t      b_i,
  input  simd_ctrl_t ctrl_i,
  input  logic       carry_i,
  output lane_out_t  lane_o,
  output logic       carry_o
);

  logic            invert_b;
  logic            elem_start;
  logic            cin;
  byte_t           b_eff;
  logic [LANE_W:0] sum_ext;

  // Compares and min/max run on a - b as well
  always_comb begin
    case (ctrl_i.op)
      OP_SUB, OP_CMPEQ, OP_CMPLT,
      OP_CMPLE, OP_MIN, OP_MAX: invert_b = 1'b1;
      default:                  invert_b = 1'b0;
    endcase
  end

  // Even lanes always open an element, odd lanes only in byte mode
  assign elem_start = (ctrl_i.width == EW_8) || (LANE_IDX % 2 == 0);

  // Two's complement +1 enters at the element's low lane
  assign cin   = elem_start ? invert_b : carry_i;
  assign b_eff = invert_b ? ~b_i : b_i;

  assign sum_ext = {1'b0, a_i} + {1'b0, b_eff} + {{LANE_W{1'b0}}, cin};

  assign lane_o.sum   = sum_ext[LANE_W-1:0];
  assign lane_o.carry = sum_ext[LANE_W];
  assign lane_o.a_msb = a_i[LANE_W-1];
  assign lane_o.b_msb = b_eff[LANE_W-1];
  assign lane_o.zero  = (sum_ext[LANE_W-1:0] == '0);

  assign carry_o = sum_ext[LANE_W];

endmodule

/* design/simd_lane_merge.sv */
`timescale 1ns/1ps
// SIMD lane merge
// Builds elements from the lane outputs and applies wrap, saturate,
// halve, compare masks and min/max selection

module simd_lane_merge import simd_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic [NUM_LANES*LANE_W-1:0] opa_i,
  input  logic [NUM_LANES*LANE_W-1:0] opb_i,
  input  lane_out_t                   lanes_i [NUM_LANES],
  input  simd_ctrl_t                  ctrl_i,
  output logic [NUM_LANES*LANE_W-1:0] result_o,
  output logic                        ovf_o
);

  logic                 is16;
  logic                 arith;
  logic                 sub_like;
  logic [NUM_LANES-1:0] clamped;

  assign is16     = (ctrl_i.width == EW_16);
  assign arith    = (ctrl_i.op == OP_ADD) || (ctrl_i.op == OP_SUB);
  assign sub_like = (ctrl_i.op != OP_ADD);

  //////////////////////////////////////////////////////////////////////
  // Per-lane view of its element
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NUM_LANES; b++) begin : gen_elem
    localparam int LO = b - (b % 2);
    localparam int HI = LO + 1;

    lane_out_t top;
    byte_t     a_byte;
    byte_t     b_byte;
    byte_t     wrap_byte;
    byte_t     sat_byte;
    byte_t     halve_byte;
    byte_t     res_byte;
    logic      is_top;
    logic      eq;
    logic      ovf_s;
    logic      ovf_u;
    logic      ovf;
    logic      neg;
    logic      half_msb;

    // Sign and carry come from the element's top lane
    assign top    = is16 ? lanes_i[HI] : lanes_i[b];
    assign is_top = !is16 || (b % 2 == 1);

    assign eq = is16 ? (lanes_i[LO].zero & lanes_i[HI].zero) : lanes_i[b].zero;

    // Same operand signs but the result sign flipped
    assign ovf_s = (top.a_msb == top.b_msb) && (top.sum[LANE_W-1] != top.a_msb);
    // Carry on add, borrow on subtract
    assign ovf_u = top.carry ^ sub_like;
    assign ovf   = ctrl_i.is_signed ? ovf_s : ovf_u;

    // Top bit of the exact result
    // Doubles as a < b for compares and min/max
    assign neg = ctrl_i.is_signed ? (top.sum[LANE_W-1] ^ ovf_s) : ovf_u;

    assign a_byte    = opa_i[b*LANE_W +: LANE_W];
    assign b_byte    = opb_i[b*LANE_W +: LANE_W];
    assign wrap_byte = lanes_i[b].sum;

    // Low byte of a halfword takes its new msb from the high lane
    assign half_msb   = is_top ? neg : lanes_i[HI].sum[0];
    assign halve_byte = {half_msb, wrap_byte[LANE_W-1:1]};

    always_comb begin
      if (!ovf) begin
        sat_byte = wrap_byte;
      end else if (!ctrl_i.is_signed) begin
        sat_byte = sub_like ? '0 : '1;
      end else if (is_top) begin
        // Negative overflow goes to the minimum
        sat_byte = top.a_msb ? {1'b1, {(LANE_W-1){1'b0}}} : {1'b0, {(LANE_W-1){1'b1}}};
      end else begin
        sat_byte = top.a_msb ? '0 : '1;
      end
    end

    always_comb begin
      case (ctrl_i.op)
        OP_ADD, OP_SUB: begin
          case (ctrl_i.mode)
            MODE_SAT:   res_byte = sat_byte;
            MODE_HALVE: res_byte = halve_byte;
            default:    res_byte = wrap_byte;
          endcase
        end
        OP_CMPEQ: res_byte = {LANE_W{eq}};
        OP_CMPLT: res_byte = {LANE_W{neg}};
        OP_CMPLE: res_byte = {LANE_W{neg | eq}};
        OP_MIN:   res_byte = neg ? a_byte : b_byte;
        OP_MAX:   res_byte = neg ? b_byte : a_byte;
        default:  res_byte = '0;
      endcase
    end

    assign result_o[b*LANE_W +: LANE_W] = res_byte;
    assign clamped[b] = arith && (ctrl_i.mode == MODE_SAT) && ovf;
  end

  assign ovf_o = |clamped;

  // Overflow is a saturating add/sub event only
  always_comb begin
    a_ovf_sat_only: assert final (!ovf_o || (arith && ctrl_i.mode == MODE_SAT))
      else $error("overflow flagged outside saturating add/sub");
  end

endmodule

/* design/simd_alu_top.sv */
`timescale 1ns/1ps
// Packed-SIMD arithmetic unit, Wishbone classic peripheral
// Register block, a chain of byte lanes and the element merge

module simd_alu_top import simd_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [2:0]                  wb_adr_i,
  input  logic [NUM_LANES*LANE_W-1:0] wb_dat_i,
  output logic [NUM_LANES*LANE_W-1:0] wb_dat_o,
  output logic                        wb_ack_o
);

  logic [NUM_LANES*LANE_W-1:0] opa;
  logic [NUM_LANES*LANE_W-1:0] opb;
  logic [NUM_LANES*LANE_W-1:0] result;
  simd_ctrl_t                  ctrl;
  logic                        ovf;
  lane_out_t                   lanes [NUM_LANES];
  logic [NUM_LANES:0]          carry;

  simd_wb_regs #(
    .NUM_LANES (NUM_LANES)
  ) i_regs (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_reg_e'(wb_adr_i)),
    .wb_dat_i (wb_dat_i),
    .result_i (result),
    .ovf_i    (ovf),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .opa_o    (opa),
    .opb_o    (opb),
    .ctrl_o   (ctrl)
  );

  // Carry ripples from lane 0 upward
  assign carry[0] = 1'b0;

  for (genvar b = 0; b < NUM_LANES; b++) begin : gen_lane
    simd_byte_lane #(
      .LANE_IDX (b)
    ) i_lane (
      .a_i     (opa[b*LANE_W +: LANE_W]),
      .b_i     (opb[b*LANE_W +: LANE_W]),
      .ctrl_i  (ctrl),
      .carry_i (carry[b]),
      .lane_o  (lanes[b]),
      .carry_o (carry[b+1])
    );
  end

  simd_lane_merge #(
    .NUM_LANES (NUM_LANES)
  ) i_merge (
    .opa_i    (opa),
    .opb_i    (opb),
    .lanes_i  (lanes),
    .ctrl_i   (ctrl),
    .result_o (result),
    .ovf_o    (ovf)
  );

endmodule

/* testbench/simd_checker.sv */
`timescale 1ns/1ps
// Bus monitor and reference model for the SIMD peripheral
// Tracks register writes, predicts every read and checks the ack handshake

module simd_checker import simd_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [2:0]                  wb_adr_i,
  input  logic [NUM_LANES*LANE_W-1:0] wb_wdat_i,
  input  logic [NUM_LANES*LANE_W-1:0] wb_rdat_i,
  input  logic                        wb_ack_i,
  output int                          value_errs_o,
  output int                          proto_errs_o
);

  localparam int DW = NUM_LANES * LANE_W;

  // Model copy of the register file
  logic [DW-1:0] opa_m;
  logic [DW-1:0] opb_m;
  logic [DW-1:0] res_m;
  logic [6:0]    ctrl_m;
  logic          ovf_m;

  // Request seen on the previous edge
  logic          req_q;
  logic          ack_q;
  logic          we_q;
  logic [2:0]    adr_q;
  logic [DW-1:0] wdat_q;

  int value_errs = 0;
  int proto_errs = 0;

  //////////////////////////////////////////////////////////////////////
  // Element-wise reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void predict(input logic [DW-1:0] a, input logic [DW-1:0] b,
                                  input logic [6:0] ctrl,
                                  output logic [DW-1:0] res, output logic ovf);
    simd_op_e  op;
    sat_mode_e mode;
    logic      sgn;
    logic      lt;
    logic      eq;
    int        ew;
    longint    mask;
    longint    ua;
    longint    ub;
    longint    va;
    longint    vb;
    longint    exact;
    longint    lo;
    longint    hi;
    longint    r;
    op   = simd_op_e'(ctrl[6:4]);
    mode = sat_mode_e'(ctrl[3:2]);
    ew   = ctrl[1] ? 16 : 8;
    sgn  = ctrl[0];
    mask = (longint'(1) << ew) - 1;
    res  = '0;
    ovf  = 1'b0;
    for (int e = 0; e < DW / ew; e++) begin
      ua = longint'(a >> (e * ew)) & mask;
      ub = longint'(b >> (e * ew)) & mask;
      va = (sgn && ua[ew-1]) ? ua - (mask + 1) : ua;
      vb = (sgn && ub[ew-1]) ? ub - (mask + 1) : ub;
      exact = (op == OP_ADD) ? va + vb : va - vb;
      lt = (va < vb);
      eq = (va == vb);
      case (op)
        OP_ADD, OP_SUB: begin
          case (mode)
            MODE_SAT: begin
              lo = sgn ? -((mask + 1) / 2) : 0;
              hi = sgn ? (mask + 1) / 2 - 1 : mask;
              r  = exact;
              if (exact > hi) begin
                r   = hi;
                ovf = 1'b1;
              end else if (exact < lo) begin
                r   = lo;
                ovf = 1'b1;
              end
            end
            // Exact value carries one extra bit before the shift
            MODE_HALVE: r = exact >>> 1;
            default:    r = exact;
          endcase
        end
        OP_CMPEQ: r = eq ? mask : 0;
        OP_CMPLT: r = lt ? mask : 0;
        OP_CMPLE: r = (lt || eq) ? mask : 0;
        OP_MIN:   r = lt ? ua : ub;
        OP_MAX:   r = lt ? ub : ua;
        default:  r = 0;
      endcase
      res = res | (DW'(r & mask) << (e * ew));
    end
  endfunction

  function automatic logic [DW-1:0] expected_read(input logic [2:0] adr);
    case (adr)
      REG_OPA:    return opa_m;
      REG_OPB:    return opb_m;
      REG_CTRL:   return {{(DW-7){1'b0}}, ctrl_m};
      REG_RESULT: return res_m;
      REG_STATUS: return {{(DW-1){1'b0}}, ovf_m};
      default:    return '0;
    endcase
  endfunction

  function automatic string reg_name(input logic [2:0] adr);
    case (adr)
      REG_OPA:    return "OPA";
      REG_OPB:    return "OPB";
      REG_CTRL:   return "CTRL";
      REG_RESULT: return "RESULT";
      REG_STATUS: return "STATUS";
      default:    return "UNMAPPED";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [DW-1:0] exp_v;
    if (!rst_n_i) begin
      opa_m  = '0;
      opb_m  = '0;
      res_m  = '0;
      ctrl_m = '0;
      ovf_m  = 1'b0;
      req_q  = 1'b0;
      ack_q  = 1'b0;
      we_q   = 1'b0;
      adr_q  = '0;
      wdat_q = '0;
    end else begin
      if (wb_ack_i && ack_q) begin
        proto_errs++;
        $display("Protocol error at %0t: ack stayed high for two cycles", $time);
      end else if (wb_ack_i && !req_q) begin
        proto_errs++;
        $display("Protocol error at %0t: ack without a request on the cycle before", $time);
      end else if (!wb_ack_i && req_q) begin
        proto_errs++;
        $display("Protocol error at %0t: no ack on the cycle after a request", $time);
      end else if (wb_ack_i && we_q) begin
        case (adr_q)
          REG_OPA: opa_m = wdat_q;
          REG_OPB: opb_m = wdat_q;
          REG_CTRL: begin
            ctrl_m = wdat_q[6:0];
            predict(opa_m, opb_m, ctrl_m, res_m, ovf_m);
          end
          default: ;
        endcase
      end else if (wb_ack_i) begin
        exp_v = expected_read(adr_q);
        if (wb_rdat_i !== exp_v) begin
          value_errs++;
          $display("FAIL t=%0t %s expected %h got %h", $time, reg_name(adr_q), exp_v,
                   wb_rdat_i);
        end
      end
      req_q  = wb_cyc_i && wb_stb_i && !wb_ack_i;
      ack_q  = wb_ack_i;
      we_q   = wb_we_i;
      adr_q  = wb_adr_i;
      wdat_q = wb_wdat_i;
    end
  end

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;

endmodule

/* testbench/tb_simd_alu.sv */
`timescale 1ns/1ps
// Testbench for the packed-SIMD Wishbone peripheral
// Random operations through Wishbone master tasks, checked by simd_checker

module tb_simd_alu import simd_pkg::*; ();

  localparam int NUM_LANES      = 4;
  localparam int DW             = NUM_LANES * LANE_W;
  localparam int N_OPS          = 400;
  // Reset, five accesses of up to four cycles per op and a margin
  localparam int TIMEOUT_CYCLES = 10 + N_OPS * 5 * 4 + 200;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  logic [2:0]    wb_adr;
  logic [DW-1:0] wb_wdat;
  logic [DW-1:0] wb_rdat;
  logic          wb_ack;
  integer        seed;
  int            cycles = 0;
  int            value_errs;
  int            proto_errs;

  always #50 clk = ~clk;

  simd_alu_top #(
    .NUM_LANES (NUM_LANES)
  ) i_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack)
  );

  simd_checker #(
    .NUM_LANES (NUM_LANES)
  ) i_checker (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_wdat_i    (wb_wdat),
    .wb_rdat_i    (wb_rdat),
    .wb_ack_i     (wb_ack),
    .value_errs_o (value_errs),
    .proto_errs_o (proto_errs)
  );

  //////////////////////////////////////////////////////////////////////
  // Wishbone master
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [2:0] adr, input logic [DW-1:0] data);
    @(negedge clk);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_adr  = adr;
    wb_wdat = data;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // Read data is compared by the checker
  task automatic bus_read(input logic [2:0] adr);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  initial begin
    logic [DW-1:0] opa;
    logic [DW-1:0] opb;
    logic [2:0]    op;
    logic [1:0]    mode;
    logic [31:0]   flags;
    seed    = 81117;
    rst_n   = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Reset values of every word including the unmapped ones
    for (int a = 0; a < 8; a++) begin
      bus_read(3'(a));
    end
    // Read-only and unmapped words ignore writes
    bus_write(REG_RESULT, '1);
    bus_write(REG_STATUS, '1);
    bus_write(3'd7, '1);
    bus_read(REG_RESULT);
    bus_read(REG_STATUS);
    bus_read(3'd7);

    for (int i = 0; i < N_OPS; i++) begin
      opa   = $random(seed);
      opb   = $random(seed);
      op    = 3'($unsigned($random(seed)) % 7);
      mode  = 2'($unsigned($random(seed)) % 3);
      flags = $random(seed);
      // Equal low halfwords so that compares also see equal elements
      if (flags[2]) begin
        opb[2*LANE_W-1:0] = opa[2*LANE_W-1:0];
      end
      bus_write(REG_OPA, opa);
      bus_write(REG_OPB, opb);
      // CTRL layout is op, mode, width, signed
      bus_write(REG_CTRL, DW'({op, mode, flags[1:0]}));
      bus_read(REG_RESULT);
      bus_read(REG_STATUS);
      if (i % 16 == 0) begin
        bus_read(REG_OPA);
        bus_read(REG_OPB);
        bus_read(REG_CTRL);
      end
    end

    repeat (2) @(negedge clk);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

/* src.f */
design/simd_pkg.sv
design/simd_wb_regs.sv
design/simd_byte_lane.sv
design/simd_lane_merge.sv
design/simd_alu_top.sv
testbench/simd_checker.sv
testbench/tb_simd_alu.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_simd_alu
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
